//--- filelist.f
src/lsu_pkg.sv
src/replay_queue.sv
src/replay_select.sv
src/lsu_pipe.sv
src/lsu_top.sv
verif/tb_lsu.sv

//--- Bender.yml
package:
  name: lsu_replay

sources:
  - files:
      - src/lsu_pkg.sv
      - src/replay_queue.sv
      - src/replay_select.sv
      - src/lsu_pipe.sv
      - src/lsu_top.sv
  - target: test
    files:
      - verif/tb_lsu.sv

//--- verif/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

   localparam int LDQ_SIZE = 4;
   localparam int STQ_SIZE = 4;

   // Requests pushed over all tests, used to bound the run
   localparam int N_PUSH  = 1 + 2 + 6 + 2 + 2 * LDQ_SIZE + 40;
   localparam int TIMEOUT = 20 * N_PUSH + 100;

   typedef struct packed {
      lsu_pkg::cmt_id_t cmt;
      lsu_pkg::grp_id_t grp;
      lsu_pkg::addr_t   addr;
      lsu_pkg::data_t   payload;
   } req_t;

   logic               i_clk;
   logic               i_reset;
   logic               i_ld_push;
   lsu_pkg::cmt_id_t   i_ld_cmt_id;
   lsu_pkg::grp_id_t   i_ld_grp_id;
   lsu_pkg::addr_t     i_ld_addr;
   lsu_pkg::rd_t       i_ld_rd;
   logic               o_ldq_full;
   logic               i_st_push;
   lsu_pkg::cmt_id_t   i_st_cmt_id;
   lsu_pkg::grp_id_t   i_st_grp_id;
   lsu_pkg::addr_t     i_st_addr;
   lsu_pkg::data_t     i_st_data;
   logic               o_stq_full;
   logic               o_wb_valid;
   lsu_pkg::rd_t       o_wb_rd;
   lsu_pkg::data_t     o_wb_data;
   logic               o_done;
   lsu_pkg::cmt_id_t   o_done_cmt_id;
   logic               o_done_is_store;

   int cycle = 0;
   int last_push_cyc = 0;
   int n_checks = 0;
   int n_errors = 0;

   // Reference model state
   lsu_pkg::data_t     ref_mem [lsu_pkg::MEM_DEPTH];
   req_t               m_ld_q[$];
   req_t               m_st_q[$];
   lsu_pkg::cmt_id_t   exp_cmt_q[$];
   logic               exp_st_q[$];
   lsu_pkg::rd_t       exp_rd_q[$];
   lsu_pkg::data_t     exp_data_q[$];

   // Observed events
   lsu_pkg::cmt_id_t   act_cmt_q[$];
   logic               act_st_q[$];
   int                 act_cyc_q[$];
   lsu_pkg::rd_t       act_rd_q[$];
   lsu_pkg::data_t     act_data_q[$];

   lsu_top #(
      .LDQ_SIZE (LDQ_SIZE),
      .STQ_SIZE (STQ_SIZE)
   ) DUT (
      .i_clk           (i_clk),
      .i_reset         (i_reset),
      .i_ld_push       (i_ld_push),
      .i_ld_cmt_id     (i_ld_cmt_id),
      .i_ld_grp_id     (i_ld_grp_id),
      .i_ld_addr       (i_ld_addr),
      .i_ld_rd         (i_ld_rd),
      .o_ldq_full      (o_ldq_full),
      .i_st_push       (i_st_push),
      .i_st_cmt_id     (i_st_cmt_id),
      .i_st_grp_id     (i_st_grp_id),
      .i_st_addr       (i_st_addr),
      .i_st_data       (i_st_data),
      .o_stq_full      (o_stq_full),
      .o_wb_valid      (o_wb_valid),
      .o_wb_rd         (o_wb_rd),
      .o_wb_data       (o_wb_data),
      .o_done          (o_done),
      .o_done_cmt_id   (o_done_cmt_id),
      .o_done_is_store (o_done_is_store)
   );

   initial begin
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk;
   end

   // ====================================================================
   // Reference model and monitor
   // ====================================================================

   // Wrap bits equal means smaller index first, else larger index first
   function automatic logic ld_is_older(input req_t ld, input req_t st);
      logic same_wrap;
      same_wrap = (ld.cmt[lsu_pkg::CMT_ID_W-1] == st.cmt[lsu_pkg::CMT_ID_W-1]);
      if (ld.cmt == st.cmt) begin
         return ld.grp < st.grp;
      end
      if (same_wrap) begin
         return ld.cmt[lsu_pkg::CMT_ID_W-2:0] < st.cmt[lsu_pkg::CMT_ID_W-2:0];
      end
      return ld.cmt[lsu_pkg::CMT_ID_W-2:0] > st.cmt[lsu_pkg::CMT_ID_W-2:0];
   endfunction

   // Admission order of the heads, then pushes taken at this edge
   always @(posedge i_clk) begin : model
      req_t head;
      logic take_ld;
      if (i_reset) begin
         m_ld_q.delete();
         m_st_q.delete();
         for (int i = 0; i < lsu_pkg::MEM_DEPTH; i++) begin
            ref_mem[i] = '0;
         end
      end else begin
         if (m_ld_q.size() > 0 || m_st_q.size() > 0) begin
            take_ld = (m_ld_q.size() > 0) &&
                      ((m_st_q.size() == 0) || ld_is_older(m_ld_q[0], m_st_q[0]));
            if (take_ld) begin
               head = m_ld_q.pop_front();
               exp_cmt_q.push_back(head.cmt);
               exp_st_q.push_back(1'b0);
               exp_rd_q.push_back(head.payload[lsu_pkg::RD_W-1:0]);
               exp_data_q.push_back(ref_mem[head.addr]);
            end else begin
               head = m_st_q.pop_front();
               ref_mem[head.addr] = head.payload;
               exp_cmt_q.push_back(head.cmt);
               exp_st_q.push_back(1'b1);
            end
         end
         if (i_ld_push) begin
            m_ld_q.push_back('{i_ld_cmt_id, i_ld_grp_id, i_ld_addr,
                               {{(lsu_pkg::DATA_W-lsu_pkg::RD_W){1'b0}}, i_ld_rd}});
            last_push_cyc = cycle;
         end
         if (i_st_push) begin
            m_st_q.push_back('{i_st_cmt_id, i_st_grp_id, i_st_addr, i_st_data});
            last_push_cyc = cycle;
         end
      end
   end

   always @(posedge i_clk) begin
      if (!i_reset && o_done) begin
         act_cmt_q.push_back(o_done_cmt_id);
         act_st_q.push_back(o_done_is_store);
         act_cyc_q.push_back(cycle);
      end
      if (!i_reset && o_wb_valid) begin
         act_rd_q.push_back(o_wb_rd);
         act_data_q.push_back(o_wb_data);
      end
   end

   // Watchdog
   always @(posedge i_clk) begin
      cycle <= cycle + 1;
      if (cycle >= TIMEOUT) begin
         $display("ERROR at %0t: run did not finish within %0d cycles", $time, TIMEOUT);
         $display("Simulation failed");
         $finish;
      end
   end

   // ====================================================================
   // Compare tasks
   // ====================================================================

   task automatic check_data(input string name, input lsu_pkg::data_t act,
                             input lsu_pkg::data_t exp);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, act, exp);
      end
   endtask

   task automatic check_rd(input string name, input lsu_pkg::rd_t act,
                           input lsu_pkg::rd_t exp);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, act, exp);
      end
   endtask

   task automatic check_cmt_id(input string name, input lsu_pkg::cmt_id_t act,
                               input lsu_pkg::cmt_id_t exp);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, act, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic act, input logic exp);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, act, exp);
      end
   endtask

   task automatic check_latency(input string name, input int act, input int exp);
      n_checks++;
      if (act != exp) begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, act, exp);
      end
   endtask

   // Full levels against the occupancy of the model queues
   always @(negedge i_clk) begin
      if (!i_reset) begin
         check_flag("o_ldq_full", o_ldq_full, m_ld_q.size() == LDQ_SIZE);
         check_flag("o_stq_full", o_stq_full, m_st_q.size() == STQ_SIZE);
      end
   end

   // Pairs observed completions and writebacks with the predicted ones
   task automatic compare_results();
      if (act_cmt_q.size() != exp_cmt_q.size() || act_rd_q.size() != exp_rd_q.size()) begin
         n_errors++;
         $display("ERROR at %0t: %0d completions and %0d writebacks seen, %0d and %0d predicted",
                  $time, act_cmt_q.size(), act_rd_q.size(), exp_cmt_q.size(), exp_rd_q.size());
      end
      while (act_cmt_q.size() > 0 && exp_cmt_q.size() > 0) begin
         check_cmt_id("o_done_cmt_id", act_cmt_q.pop_front(), exp_cmt_q.pop_front());
         check_flag("o_done_is_store", act_st_q.pop_front(), exp_st_q.pop_front());
      end
      while (act_rd_q.size() > 0 && exp_rd_q.size() > 0) begin
         check_rd("o_wb_rd", act_rd_q.pop_front(), exp_rd_q.pop_front());
         check_data("o_wb_data", act_data_q.pop_front(), exp_data_q.pop_front());
      end
      act_cmt_q.delete();
      act_st_q.delete();
      act_cyc_q.delete();
      act_rd_q.delete();
      act_data_q.delete();
      exp_cmt_q.delete();
      exp_st_q.delete();
      exp_rd_q.delete();
      exp_data_q.delete();
   endtask

   // ====================================================================
   // Stimulus helpers
   // ====================================================================

   // One push cycle on either or both queues once room is there
   task automatic push_reqs(
      input logic do_ld, input lsu_pkg::cmt_id_t ld_cmt, input lsu_pkg::grp_id_t ld_grp,
      input lsu_pkg::addr_t ld_addr, input lsu_pkg::rd_t ld_rd,
      input logic do_st, input lsu_pkg::cmt_id_t st_cmt, input lsu_pkg::grp_id_t st_grp,
      input lsu_pkg::addr_t st_addr, input lsu_pkg::data_t st_data
   );
      @(negedge i_clk);
      while ((do_ld && o_ldq_full) || (do_st && o_stq_full)) begin
         @(negedge i_clk);
      end
      @(posedge i_clk);
      i_ld_push   <= do_ld;
      i_ld_cmt_id <= ld_cmt;
      i_ld_grp_id <= ld_grp;
      i_ld_addr   <= ld_addr;
      i_ld_rd     <= ld_rd;
      i_st_push   <= do_st;
      i_st_cmt_id <= st_cmt;
      i_st_grp_id <= st_grp;
      i_st_addr   <= st_addr;
      i_st_data   <= st_data;
      @(posedge i_clk);
      i_ld_push <= 1'b0;
      i_st_push <= 1'b0;
   endtask

   task automatic wait_done(input int n);
      while (act_cmt_q.size() < n) begin
         @(negedge i_clk);
      end
   endtask

   // ====================================================================
   // Directed tests
   // ====================================================================

   task automatic test_load_after_reset();
      lsu_pkg::addr_t addr;
      addr = $urandom_range(0, 63);
      push_reqs(1'b1, 5'h00, 2'd0, addr, 5'd3, 1'b0, 5'h00, 2'd0, 6'd0, 32'd0);
      wait_done(1);
      check_latency("o_done latency", act_cyc_q[0] - last_push_cyc, 5);
      check_data("o_wb_data after reset", act_data_q[0], 32'd0);
      compare_results();
   endtask

   task automatic test_store_then_load();
      lsu_pkg::addr_t addr;
      lsu_pkg::data_t data;
      addr = $urandom_range(0, 63);
      data = $urandom;
      push_reqs(1'b0, 5'h00, 2'd0, 6'd0, 5'd0, 1'b1, 5'h01, 2'd0, addr, data);
      push_reqs(1'b1, 5'h02, 2'd0, addr, 5'd7, 1'b0, 5'h00, 2'd0, 6'd0, 32'd0);
      wait_done(2);
      compare_results();
   endtask

   task automatic test_same_cycle_pair();
      lsu_pkg::addr_t addr;
      addr = $urandom_range(0, 63);
      // Load older, then store older, then a tie on commit id
      push_reqs(1'b1, 5'h03, 2'd0, addr, 5'd9, 1'b1, 5'h04, 2'd0, addr, $urandom);
      push_reqs(1'b1, 5'h06, 2'd0, addr, 5'd10, 1'b1, 5'h05, 2'd0, addr, $urandom);
      push_reqs(1'b1, 5'h07, 2'd1, addr, 5'd11, 1'b1, 5'h07, 2'd0, addr, $urandom);
      wait_done(6);
      compare_results();
   endtask

   task automatic test_wrap_order();
      lsu_pkg::addr_t addr;
      addr = $urandom_range(0, 63);
      push_reqs(1'b1, 5'h0e, 2'd0, addr, 5'd12, 1'b1, 5'h11, 2'd0, addr, $urandom);
      wait_done(2);
      check_flag("first o_done_is_store", act_st_q[0], 1'b0);
      compare_results();
   endtask

   // Older stores keep winning so the loads pile up
   task automatic test_fill_ldq();
      lsu_pkg::cmt_id_t st_cmt;
      lsu_pkg::cmt_id_t ld_cmt;
      bit seen_full;
      st_cmt = 5'h00;
      ld_cmt = LDQ_SIZE;
      for (int i = 0; i < LDQ_SIZE; i++) begin
         @(posedge i_clk);
         i_st_push   <= 1'b1;
         i_st_cmt_id <= st_cmt;
         i_st_grp_id <= 2'd0;
         i_st_addr   <= $urandom_range(0, 63);
         i_st_data   <= $urandom;
         i_ld_push   <= 1'b1;
         i_ld_cmt_id <= ld_cmt;
         i_ld_grp_id <= 2'd0;
         i_ld_addr   <= $urandom_range(0, 63);
         i_ld_rd     <= $urandom_range(0, 31);
         st_cmt = st_cmt + 1'b1;
         ld_cmt = ld_cmt + 1'b1;
      end
      @(posedge i_clk);
      i_st_push <= 1'b0;
      i_ld_push <= 1'b0;
      seen_full = 1'b0;
      for (int i = 0; i < LDQ_SIZE + 2 && !seen_full; i++) begin
         @(negedge i_clk);
         seen_full = o_ldq_full;
      end
      if (!seen_full) begin
         n_errors++;
         $display("ERROR at %0t: o_ldq_full never rose during the load burst", $time);
      end
      wait_done(2 * LDQ_SIZE);
      check_flag("o_ldq_full after drain", o_ldq_full, 1'b0);
      compare_results();
   endtask

   task automatic test_random_traffic();
      lsu_pkg::cmt_id_t cmt;
      lsu_pkg::cmt_id_t ld_cmt;
      lsu_pkg::cmt_id_t st_cmt;
      int issued;
      int kind;
      cmt = 5'h00;
      issued = 0;
      while (issued < 40) begin
         // 0 load, 1 store, 2 both in one cycle
         kind = $urandom_range(0, 2);
         if (kind == 2 && issued == 39) begin
            kind = 0;
         end
         ld_cmt = cmt;
         st_cmt = cmt;
         if (kind == 2) begin
            if ($urandom_range(0, 1) == 1) begin
               ld_cmt = cmt + 1'b1;
            end else begin
               st_cmt = cmt + 1'b1;
            end
         end
         push_reqs(kind != 1, ld_cmt, 2'd0, $urandom_range(0, 7), $urandom_range(0, 31),
                   kind != 0, st_cmt, 2'd0, $urandom_range(0, 7), $urandom);
         issued = issued + ((kind == 2) ? 2 : 1);
         cmt = cmt + ((kind == 2) ? 2'd2 : 2'd1);
      end
      wait_done(40);
      compare_results();
   endtask

   // ====================================================================
   // Main sequence
   // ====================================================================

   initial begin
      void'($urandom(32'h44f6));
      i_reset     <= 1'b1;
      i_ld_push   <= 1'b0;
      i_ld_cmt_id <= '0;
      i_ld_grp_id <= '0;
      i_ld_addr   <= '0;
      i_ld_rd     <= '0;
      i_st_push   <= 1'b0;
      i_st_cmt_id <= '0;
      i_st_grp_id <= '0;
      i_st_addr   <= '0;
      i_st_data   <= '0;
      repeat (4) @(posedge i_clk);
      i_reset <= 1'b0;

      test_load_after_reset();
      test_store_then_load();
      test_same_cycle_pair();
      test_wrap_order();
      test_fill_ldq();
      test_random_traffic();

      repeat (5) @(posedge i_clk);
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- src/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
   parameter int LDQ_SIZE = 4,
   parameter int STQ_SIZE = 4
) (
   input  logic               i_clk,
   input  logic               i_reset,

   // Load push
   input  logic               i_ld_push,
   input  lsu_pkg::cmt_id_t   i_ld_cmt_id,
   input  lsu_pkg::grp_id_t   i_ld_grp_id,
   input  lsu_pkg::addr_t     i_ld_addr,
   input  lsu_pkg::rd_t       i_ld_rd,
   output logic               o_ldq_full,

   // Store push
   input  logic               i_st_push,
   input  lsu_pkg::cmt_id_t   i_st_cmt_id,
   input  lsu_pkg::grp_id_t   i_st_grp_id,
   input  lsu_pkg::addr_t     i_st_addr,
   input  lsu_pkg::data_t     i_st_data,
   output logic               o_stq_full,

   output logic               o_wb_valid,
   output lsu_pkg::rd_t       o_wb_rd,
   output lsu_pkg::data_t     o_wb_data,
   output logic               o_done,
   output lsu_pkg::cmt_id_t   o_done_cmt_id,
   output logic               o_done_is_store
);

   // Load head
   logic               w_ld_valid;
   lsu_pkg::cmt_id_t   w_ld_cmt_id;
   lsu_pkg::grp_id_t   w_ld_grp_id;
   lsu_pkg::addr_t     w_ld_addr;
   lsu_pkg::rd_t       w_ld_rd;
   logic               w_ld_conflict;

   // Store head
   logic               w_st_valid;
   lsu_pkg::cmt_id_t   w_st_cmt_id;
   lsu_pkg::grp_id_t   w_st_grp_id;
   lsu_pkg::addr_t     w_st_addr;
   lsu_pkg::data_t     w_st_data;
   logic               w_st_conflict;

   // ex0 issue
   logic               w_ex0_valid;
   logic               w_ex0_is_store;
   lsu_pkg::cmt_id_t   w_ex0_cmt_id;
   lsu_pkg::addr_t     w_ex0_addr;
   lsu_pkg::rd_t       w_ex0_rd;
   lsu_pkg::data_t     w_ex0_data;

   // ====================================================================
   // Replay queues
   // ====================================================================

   replay_queue #(
      .Q_SIZE    (LDQ_SIZE),
      .PAYLOAD_W (lsu_pkg::RD_W)
   ) u_ldq (
      .i_clk          (i_clk),
      .i_reset        (i_reset),
      .i_push         (i_ld_push),
      .i_push_cmt_id  (i_ld_cmt_id),
      .i_push_grp_id  (i_ld_grp_id),
      .i_push_addr    (i_ld_addr),
      .i_push_payload (i_ld_rd),
      .o_full         (o_ldq_full),
      .o_req_valid    (w_ld_valid),
      .o_req_cmt_id   (w_ld_cmt_id),
      .o_req_grp_id   (w_ld_grp_id),
      .o_req_addr     (w_ld_addr),
      .o_req_payload  (w_ld_rd),
      .i_req_conflict (w_ld_conflict)
   );

   replay_queue #(
      .Q_SIZE    (STQ_SIZE),
      .PAYLOAD_W (lsu_pkg::DATA_W)
   ) u_stq (
      .i_clk          (i_clk),
      .i_reset        (i_reset),
      .i_push         (i_st_push),
      .i_push_cmt_id  (i_st_cmt_id),
      .i_push_grp_id  (i_st_grp_id),
      .i_push_addr    (i_st_addr),
      .i_push_payload (i_st_data),
      .o_full         (o_stq_full),
      .o_req_valid    (w_st_valid),
      .o_req_cmt_id   (w_st_cmt_id),
      .o_req_grp_id   (w_st_grp_id),
      .o_req_addr     (w_st_addr),
      .o_req_payload  (w_st_data),
      .i_req_conflict (w_st_conflict)
   );

   // ====================================================================
   // Age select and pipe
   // ====================================================================

   replay_select u_select (
      .i_clk          (i_clk),
      .i_reset        (i_reset),
      .i_ld_valid     (w_ld_valid),
      .i_ld_cmt_id    (w_ld_cmt_id),
      .i_ld_grp_id    (w_ld_grp_id),
      .i_ld_addr      (w_ld_addr),
      .i_ld_rd        (w_ld_rd),
      .i_st_valid     (w_st_valid),
      .i_st_cmt_id    (w_st_cmt_id),
      .i_st_grp_id    (w_st_grp_id),
      .i_st_addr      (w_st_addr),
      .i_st_data      (w_st_data),
      .o_ld_conflict  (w_ld_conflict),
      .o_st_conflict  (w_st_conflict),
      .o_ex0_valid    (w_ex0_valid),
      .o_ex0_is_store (w_ex0_is_store),
      .o_ex0_cmt_id   (w_ex0_cmt_id),
      .o_ex0_addr     (w_ex0_addr),
      .o_ex0_rd       (w_ex0_rd),
      .o_ex0_data     (w_ex0_data)
   );

   lsu_pipe u_pipe (
      .i_clk           (i_clk),
      .i_reset         (i_reset),
      .i_ex0_valid     (w_ex0_valid),
      .i_ex0_is_store  (w_ex0_is_store),
      .i_ex0_cmt_id    (w_ex0_cmt_id),
      .i_ex0_addr      (w_ex0_addr),
      .i_ex0_rd        (w_ex0_rd),
      .i_ex0_data      (w_ex0_data),
      .o_wb_valid      (o_wb_valid),
      .o_wb_rd         (o_wb_rd),
      .o_wb_data       (o_wb_data),
      .o_done          (o_done),
      .o_done_cmt_id   (o_done_cmt_id),
      .o_done_is_store (o_done_is_store)
   );

endmodule

//--- src/lsu_pipe.sv
`timescale 1ns/1ps

module lsu_pipe (
   input  logic               i_clk,
   input  logic               i_reset,

   // From the ex0 issue register
   input  logic               i_ex0_valid,
   input  logic               i_ex0_is_store,
   input  lsu_pkg::cmt_id_t   i_ex0_cmt_id,
   input  lsu_pkg::addr_t     i_ex0_addr,
   input  lsu_pkg::rd_t       i_ex0_rd,
   input  lsu_pkg::data_t     i_ex0_data,

   // Load writeback
   output logic               o_wb_valid,
   output lsu_pkg::rd_t       o_wb_rd,
   output lsu_pkg::data_t     o_wb_data,

   // Completion
   output logic               o_done,
   output lsu_pkg::cmt_id_t   o_done_cmt_id,
   output logic               o_done_is_store
);

   // ex1 stage
   logic               r_ex1_valid;
   logic               r_ex1_is_store;
   lsu_pkg::cmt_id_t   r_ex1_cmt_id;
   lsu_pkg::addr_t     r_ex1_addr;
   lsu_pkg::rd_t       r_ex1_rd;
   lsu_pkg::data_t     r_ex1_data;
   lsu_pkg::data_t     w_ex1_rdata;

   // ex2 stage
   logic               r_ex2_valid;
   logic               r_ex2_is_store;
   lsu_pkg::cmt_id_t   r_ex2_cmt_id;
   lsu_pkg::rd_t       r_ex2_rd;
   lsu_pkg::data_t     r_ex2_data;

   lsu_pkg::data_t     r_mem [lsu_pkg::MEM_DEPTH];

   // ====================================================================
   // ex1: memory access
   // ====================================================================

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         r_ex1_valid <= 1'b0;
      end else begin
         r_ex1_valid <= i_ex0_valid;
      end
   end

   always_ff @(posedge i_clk) begin
      r_ex1_is_store <= i_ex0_is_store;
      r_ex1_cmt_id   <= i_ex0_cmt_id;
      r_ex1_addr     <= i_ex0_addr;
      r_ex1_rd       <= i_ex0_rd;
      r_ex1_data     <= i_ex0_data;
   end

   // Store lands at the end of ex1, visible to the next load in ex1
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         for (int i = 0; i < lsu_pkg::MEM_DEPTH; i++) begin
            r_mem[i] <= '0;
         end
      end else if (r_ex1_valid && r_ex1_is_store) begin
         r_mem[r_ex1_addr] <= r_ex1_data;
      end
   end

   assign w_ex1_rdata = r_mem[r_ex1_addr];

   // ====================================================================
   // ex2 and ex3: result transport
   // ====================================================================

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         r_ex2_valid <= 1'b0;
         o_wb_valid  <= 1'b0;
         o_done      <= 1'b0;
      end else begin
         r_ex2_valid <= r_ex1_valid;
         o_wb_valid  <= r_ex2_valid & ~r_ex2_is_store;
         o_done      <= r_ex2_valid;
      end
   end

   always_ff @(posedge i_clk) begin
      r_ex2_is_store  <= r_ex1_is_store;
      r_ex2_cmt_id    <= r_ex1_cmt_id;
      r_ex2_rd        <= r_ex1_rd;
      r_ex2_data      <= w_ex1_rdata;
      o_wb_rd         <= r_ex2_rd;
      o_wb_data       <= r_ex2_data;
      o_done_cmt_id   <= r_ex2_cmt_id;
      o_done_is_store <= r_ex2_is_store;
   end

   a_wb_is_load_done : assert property (@(posedge i_clk) disable iff (i_reset)
      o_wb_valid |-> (o_done && !o_done_is_store))
      else $error("lsu_pipe: writeback without a matching load completion");

endmodule

//--- src/replay_select.sv
`timescale 1ns/1ps

module replay_select (
   input  logic               i_clk,
   input  logic               i_reset,

   // Load queue head
   input  logic               i_ld_valid,
   input  lsu_pkg::cmt_id_t   i_ld_cmt_id,
   input  lsu_pkg::grp_id_t   i_ld_grp_id,
   input  lsu_pkg::addr_t     i_ld_addr,
   input  lsu_pkg::rd_t       i_ld_rd,

   // Store queue head
   input  logic               i_st_valid,
   input  lsu_pkg::cmt_id_t   i_st_cmt_id,
   input  lsu_pkg::grp_id_t   i_st_grp_id,
   input  lsu_pkg::addr_t     i_st_addr,
   input  lsu_pkg::data_t     i_st_data,

   output logic               o_ld_conflict,
   output logic               o_st_conflict,

   // ex0 issue register
   output logic               o_ex0_valid,
   output logic               o_ex0_is_store,
   output lsu_pkg::cmt_id_t   o_ex0_cmt_id,
   output lsu_pkg::addr_t     o_ex0_addr,
   output lsu_pkg::rd_t       o_ex0_rd,
   output lsu_pkg::data_t     o_ex0_data
);

   logic w_ld_older;
   logic w_ld_win;

   // True when a is older than b
   function automatic logic is_older(
      input lsu_pkg::cmt_id_t a_cmt,
      input lsu_pkg::grp_id_t a_grp,
      input lsu_pkg::cmt_id_t b_cmt,
      input lsu_pkg::grp_id_t b_grp
   );
      logic [lsu_pkg::CMT_IDX_W-1:0] a_idx;
      logic [lsu_pkg::CMT_IDX_W-1:0] b_idx;
      a_idx = a_cmt[lsu_pkg::CMT_IDX_W-1:0];
      b_idx = b_cmt[lsu_pkg::CMT_IDX_W-1:0];
      if (a_cmt == b_cmt) begin
         return a_grp < b_grp;
      end else if (a_cmt[lsu_pkg::CMT_ID_W-1] == b_cmt[lsu_pkg::CMT_ID_W-1]) begin
         return a_idx < b_idx;
      end else begin
         // ROB wrapped between the two, larger index went in first
         return a_idx > b_idx;
      end
   endfunction

   assign w_ld_older = is_older(i_ld_cmt_id, i_ld_grp_id, i_st_cmt_id, i_st_grp_id);
   assign w_ld_win   = i_ld_valid & (~i_st_valid | w_ld_older);

   assign o_ld_conflict = i_ld_valid & ~w_ld_win;
   assign o_st_conflict = i_st_valid &  w_ld_win;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_ex0_valid <= 1'b0;
      end else begin
         o_ex0_valid <= i_ld_valid | i_st_valid;
      end
   end

   // Winner fields, the unused half zeroed
   always_ff @(posedge i_clk) begin
      o_ex0_is_store <= ~w_ld_win;
      o_ex0_cmt_id   <= w_ld_win ? i_ld_cmt_id : i_st_cmt_id;
      o_ex0_addr     <= w_ld_win ? i_ld_addr   : i_st_addr;
      o_ex0_rd       <= w_ld_win ? i_ld_rd     : '0;
      o_ex0_data     <= w_ld_win ? '0          : i_st_data;
   end

   // Exactly one head is older when both are valid, so only one side holds
   a_one_conflict : assert property (@(posedge i_clk) disable iff (i_reset)
      (i_ld_valid && i_st_valid) |->
         (w_ld_older != is_older(i_st_cmt_id, i_st_grp_id, i_ld_cmt_id, i_ld_grp_id)))
      else $error("replay_select: load and store heads have no defined age order");

endmodule

//--- src/replay_queue.sv
`timescale 1ns/1ps

module replay_queue #(
   parameter int Q_SIZE = 4,
   parameter int PAYLOAD_W = 32
) (
   input  logic                   i_clk,
   input  logic                   i_reset,

   // Push side
   input  logic                   i_push,
   input  lsu_pkg::cmt_id_t       i_push_cmt_id,
   input  lsu_pkg::grp_id_t       i_push_grp_id,
   input  lsu_pkg::addr_t         i_push_addr,
   input  logic [PAYLOAD_W-1:0]   i_push_payload,
   output logic                   o_full,

   // Head request toward the selector
   output logic                   o_req_valid,
   output lsu_pkg::cmt_id_t       o_req_cmt_id,
   output lsu_pkg::grp_id_t       o_req_grp_id,
   output lsu_pkg::addr_t         o_req_addr,
   output logic [PAYLOAD_W-1:0]   o_req_payload,
   input  logic                   i_req_conflict
);

   localparam int PTR_W = $clog2(Q_SIZE);

   // Entry storage
   lsu_pkg::cmt_id_t       r_cmt_id  [Q_SIZE];
   lsu_pkg::grp_id_t       r_grp_id  [Q_SIZE];
   lsu_pkg::addr_t         r_addr    [Q_SIZE];
   logic [PAYLOAD_W-1:0]   r_payload [Q_SIZE];

   logic [PTR_W-1:0]       r_head;
   logic [PTR_W-1:0]       r_tail;
   logic [PTR_W-1:0]       w_head_nxt;
   logic [PTR_W-1:0]       w_tail_nxt;
   lsu_pkg::mem_state_t    r_state;

   logic                   w_push;
   logic                   w_pop;

   assign o_full      = (r_state == lsu_pkg::Q_FULL);
   assign o_req_valid = (r_state != lsu_pkg::Q_EMPTY);

   assign o_req_cmt_id  = r_cmt_id[r_head];
   assign o_req_grp_id  = r_grp_id[r_head];
   assign o_req_addr    = r_addr[r_head];
   assign o_req_payload = r_payload[r_head];

   // A push into a full queue is lost
   assign w_push = i_push & ~o_full;
   // Head leaves unless the selector picked the other queue
   assign w_pop  = o_req_valid & ~i_req_conflict;

   assign w_head_nxt = r_head + 1'b1;
   assign w_tail_nxt = r_tail + 1'b1;

   always_ff @(posedge i_clk) begin
      if (w_push) begin
         r_cmt_id[r_tail]  <= i_push_cmt_id;
         r_grp_id[r_tail]  <= i_push_grp_id;
         r_addr[r_tail]    <= i_push_addr;
         r_payload[r_tail] <= i_push_payload;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         r_head  <= '0;
         r_tail  <= '0;
         r_state <= lsu_pkg::Q_EMPTY;
      end else begin
         if (w_push) begin
            r_tail <= w_tail_nxt;
         end
         if (w_pop) begin
            r_head <= w_head_nxt;
         end

         // Occupancy only moves when exactly one side is active
         if (w_push && !w_pop) begin
            r_state <= (w_tail_nxt == r_head) ? lsu_pkg::Q_FULL : lsu_pkg::Q_PARTIAL;
         end else if (w_pop && !w_push) begin
            r_state <= (w_head_nxt == r_tail) ? lsu_pkg::Q_EMPTY : lsu_pkg::Q_PARTIAL;
         end
      end
   end

   // ====================================================================
   // Checks
   // ====================================================================

   a_no_push_when_full : assert property (@(posedge i_clk) disable iff (i_reset)
      i_push |-> !o_full)
      else $error("replay_queue: push dropped while full");

   // Pointers meet only when empty or full
   a_state_vs_ptr : assert property (@(posedge i_clk) disable iff (i_reset)
      (r_state == lsu_pkg::Q_PARTIAL) == (r_head != r_tail))
      else $error("replay_queue: occupancy state disagrees with pointers");

endmodule

//--- src/lsu_pkg.sv
package lsu_pkg;

   // ====================================================================
   // Commit and group ordering
   // ====================================================================

   // 4-bit reorder-buffer index plus a wrap bit on top
   localparam int CMT_ID_W = 5;
   localparam int CMT_IDX_W = CMT_ID_W - 1;

   typedef logic [CMT_ID_W-1:0] cmt_id_t;

   // Slot inside a dispatch group, lower is older
   localparam int GRP_ID_W = 2;

   typedef logic [GRP_ID_W-1:0] grp_id_t;

   // ====================================================================
   // Memory access fields
   // ====================================================================

   // Word address into the data memory
   localparam int ADDR_W = 6;
   localparam int MEM_DEPTH = 1 << ADDR_W;

   typedef logic [ADDR_W-1:0] addr_t;

   localparam int DATA_W = 32;

   typedef logic [DATA_W-1:0] data_t;

   // Load destination register
   localparam int RD_W = 5;

   typedef logic [RD_W-1:0] rd_t;

   // ====================================================================
   // Replay queue occupancy
   // ====================================================================

   typedef enum logic [1:0] {
      Q_EMPTY,
      Q_PARTIAL,
      Q_FULL
   } mem_state_t;

endpackage
